// ==== logic/emu_mgmt_defines.svh ====
`ifndef EMU_MGMT_DEFINES_SVH
`define EMU_MGMT_DEFINES_SVH

// ======================================================================
// Reset timing
// ======================================================================

// Cycles that sys_reset stays high after a reset-apply edge
`define EMU_RST_STRETCH 8

// ======================================================================
// Disk activity LEDs
// ======================================================================

// Hold time after the last busy cycle
// Short for simulation
// Hardware would use a few million cycles
`define EMU_LED_HOLD 64

// ======================================================================
// Management bus widths
// ======================================================================

`define EMU_ADDR_W 32
`define EMU_DATA_W 32

`endif

// ==== logic/emu_mgmt_pkg.sv ====
`include "emu_mgmt_defines.svh"

package emu_mgmt_pkg;

	// Management bus address and data
	typedef logic [`EMU_ADDR_W-1:0] mgmt_addr_t;
	typedef logic [`EMU_DATA_W-1:0] mgmt_data_t;

	// Reset stretch counter sized for EMU_RST_STRETCH
	typedef logic [3:0] rst_count_t;

	// LED hold counter sized for EMU_LED_HOLD
	typedef logic [6:0] led_count_t;

	// Access sequencer states
	// Issue states hold the command until waitrequest drops
	typedef enum logic [2:0] {
		ACC_IDLE     = 3'd0,
		ACC_RD_ISSUE = 3'd1,
		ACC_RD_WAIT  = 3'd2,
		ACC_WR_ISSUE = 3'd3,
		ACC_WR_DONE  = 3'd4
	} access_state_t;

endpackage

// ==== logic/mgmt_access_fsm.sv ====
`timescale 1ns/1ps

module mgmt_access_fsm (
	input  logic                     clk_sys,
	input  logic                     rst_n,

	// Host request side
	input  logic                     host_rd,
	input  logic                     host_wr,
	input  emu_mgmt_pkg::mgmt_addr_t host_addr,
	input  emu_mgmt_pkg::mgmt_data_t host_wdata,
	output logic                     io_wait,
	output emu_mgmt_pkg::mgmt_data_t host_rdata,

	// Management bus master
	input  logic                     mgmt_waitrequest,
	input  logic                     mgmt_rdatavalid,
	input  emu_mgmt_pkg::mgmt_data_t mgmt_rdata,
	output logic                     mgmt_read,
	output logic                     mgmt_write,
	output emu_mgmt_pkg::mgmt_addr_t mgmt_addr,
	output emu_mgmt_pkg::mgmt_data_t mgmt_wdata,

	input  logic                     sys_reset
);
	import emu_mgmt_pkg::*;

	access_state_t state;
	logic          sys_reset_q;
	logic          abort;
	logic          rd_accept;
	logic          wr_accept;

	// Rising edge of the system reset kills the access in flight
	assign abort = sys_reset & ~sys_reset_q;

	// Command accepted on the first cycle without waitrequest
	assign rd_accept = mgmt_read & ~mgmt_waitrequest;
	assign wr_accept = mgmt_write & ~mgmt_waitrequest;

	// ======================================================================
	// Request payload and read data
	// ======================================================================

	always_ff @(posedge clk_sys) begin
		if (host_rd | host_wr) begin
			mgmt_addr <= host_addr;
		end
		if (host_wr) begin
			mgmt_wdata <= host_wdata;
		end
		if (state == ACC_RD_WAIT && mgmt_rdatavalid && !abort) begin
			host_rdata <= mgmt_rdata;
		end
	end

	// ======================================================================
	// Access sequencer
	// ======================================================================

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			state       <= ACC_IDLE;
			io_wait     <= 1'b0;
			mgmt_read   <= 1'b0;
			mgmt_write  <= 1'b0;
			sys_reset_q <= 1'b1;
		end else begin
			sys_reset_q <= sys_reset;

			if (abort) begin
				state      <= ACC_IDLE;
				io_wait    <= 1'b0;
				mgmt_read  <= 1'b0;
				mgmt_write <= 1'b0;
			end else if (host_wr) begin
				// Write wins if the host ever pulses both
				state   <= ACC_WR_ISSUE;
				io_wait <= 1'b1;
			end else if (host_rd) begin
				state   <= ACC_RD_ISSUE;
				io_wait <= 1'b1;
			end else begin
				case (state)
					ACC_RD_ISSUE: begin
						if (!mgmt_read) begin
							mgmt_read <= 1'b1;
						end else if (rd_accept) begin
							mgmt_read <= 1'b0;
							state     <= ACC_RD_WAIT;
						end
					end
					ACC_RD_WAIT: begin
						// Data is latched in the payload block above
						if (mgmt_rdatavalid) begin
							io_wait <= 1'b0;
							state   <= ACC_IDLE;
						end
					end
					ACC_WR_ISSUE: begin
						if (!mgmt_write) begin
							mgmt_write <= 1'b1;
						end else if (wr_accept) begin
							mgmt_write <= 1'b0;
							io_wait    <= 1'b0;
							state      <= ACC_WR_DONE;
						end
					end
					ACC_WR_DONE: begin
						state <= ACC_IDLE;
					end
					default: begin
						state <= ACC_IDLE;
					end
				endcase
			end
		end
	end

endmodule

// ==== logic/reset_sequencer.sv ====
`timescale 1ns/1ps

`include "emu_mgmt_defines.svh"

module reset_sequencer (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic status_reset,
	input  logic user_button,
	input  logic kbd_reset_n,
	output logic sys_reset,
	output logic cpu_reset
);
	import emu_mgmt_pkg::*;

	logic [1:0] status_sync;
	logic       status_q;
	logic       apply_edge;
	rst_count_t stretch_cnt;
	logic       init_done;
	logic       cpu_rst_q;

	// Edge seen after the second synchronizer stage
	assign apply_edge = status_sync[1] & ~status_q;

	// ======================================================================
	// Reset-apply synchronizer and stretch
	// ======================================================================

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			status_sync <= 2'b00;
			status_q    <= 1'b0;
			stretch_cnt <= '0;
			init_done   <= 1'b0;
		end else begin
			status_sync <= {status_sync[0], status_reset};
			status_q    <= status_sync[1];

			if (apply_edge) begin
				stretch_cnt <= rst_count_t'(`EMU_RST_STRETCH);
				init_done   <= 1'b1;
			end else if (stretch_cnt != '0) begin
				stretch_cnt <= rst_count_t'(stretch_cnt - 1'b1);
			end
		end
	end

	// System stays in reset until the host applies the first config
	assign sys_reset = (stretch_cnt != '0) | ~init_done;

	// ======================================================================
	// CPU reset
	// ======================================================================

	// Registered OR of the raw reset sources
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cpu_rst_q <= 1'b0;
		end else begin
			cpu_rst_q <= user_button | status_reset | ~kbd_reset_n;
		end
	end

	assign cpu_reset = cpu_rst_q | sys_reset;

endmodule

// ==== logic/activity_indicator.sv ====
`timescale 1ns/1ps

`include "emu_mgmt_defines.svh"

module activity_indicator (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic io_wait,
	input  logic device,
	input  logic sys_reset,
	output logic led_hdd,
	output logic led_fdd
);
	import emu_mgmt_pkg::*;

	// Index 0 is the floppy, index 1 the hard disk
	led_count_t hold_cnt [2];
	logic [1:0] busy;
	logic [1:0] lit;

	// Busy while the host waits on an access for that device
	assign busy[0] = io_wait & ~device;
	assign busy[1] = io_wait & device;

	// ======================================================================
	// Hold counters
	// ======================================================================

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			for (int i = 0; i < 2; i++) begin
				hold_cnt[i] <= '0;
			end
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (busy[i]) begin
					hold_cnt[i] <= led_count_t'(`EMU_LED_HOLD);
				end else if (hold_cnt[i] != '0) begin
					hold_cnt[i] <= led_count_t'(hold_cnt[i] - 1'b1);
				end
			end
		end
	end

	assign lit[0] = (hold_cnt[0] != '0);
	assign lit[1] = (hold_cnt[1] != '0);

	// Both LEDs dark while the system is held in reset
	assign led_fdd = lit[0] & ~sys_reset;
	assign led_hdd = lit[1] & ~sys_reset;

endmodule

// ==== logic/emu_mgmt_top.sv ====
`timescale 1ns/1ps

module emu_mgmt_top (
	input  logic                     clk_sys,
	input  logic                     rst_n,

	// Host side
	input  logic                     host_rd,
	input  logic                     host_wr,
	input  emu_mgmt_pkg::mgmt_addr_t host_addr,
	input  emu_mgmt_pkg::mgmt_data_t host_wdata,
	output logic                     io_wait,
	output emu_mgmt_pkg::mgmt_data_t host_rdata,

	// Management bus
	input  logic                     mgmt_waitrequest,
	input  logic                     mgmt_rdatavalid,
	input  emu_mgmt_pkg::mgmt_data_t mgmt_rdata,
	output logic                     mgmt_read,
	output logic                     mgmt_write,
	output emu_mgmt_pkg::mgmt_addr_t mgmt_addr,
	output emu_mgmt_pkg::mgmt_data_t mgmt_wdata,

	// Reset sources and results
	input  logic                     status_reset,
	input  logic                     user_button,
	input  logic                     kbd_reset_n,
	output logic                     sys_reset,
	output logic                     cpu_reset,

	// Disk activity
	input  logic                     device,
	output logic                     led_hdd,
	output logic                     led_fdd
);
	import emu_mgmt_pkg::*;

	// ======================================================================
	// Host to management bus
	// ======================================================================

	mgmt_access_fsm u_access (
		.clk_sys          (clk_sys),
		.rst_n            (rst_n),
		.host_rd          (host_rd),
		.host_wr          (host_wr),
		.host_addr        (host_addr),
		.host_wdata       (host_wdata),
		.io_wait          (io_wait),
		.host_rdata       (host_rdata),
		.mgmt_waitrequest (mgmt_waitrequest),
		.mgmt_rdatavalid  (mgmt_rdatavalid),
		.mgmt_rdata       (mgmt_rdata),
		.mgmt_read        (mgmt_read),
		.mgmt_write       (mgmt_write),
		.mgmt_addr        (mgmt_addr),
		.mgmt_wdata       (mgmt_wdata),
		.sys_reset        (sys_reset)
	);

	// ======================================================================
	// Resets
	// ======================================================================

	reset_sequencer u_reset (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.status_reset (status_reset),
		.user_button  (user_button),
		.kbd_reset_n  (kbd_reset_n),
		.sys_reset    (sys_reset),
		.cpu_reset    (cpu_reset)
	);

	// Disk LEDs follow io_wait for the selected device
	activity_indicator u_activity (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.io_wait   (io_wait),
		.device    (device),
		.sys_reset (sys_reset),
		.led_hdd   (led_hdd),
		.led_fdd   (led_fdd)
	);

endmodule

// ==== sim/emu_mgmt_assertions.sv ====
`timescale 1ns/1ps

module emu_mgmt_assertions (
	input logic                     clk_sys,
	input logic                     rst_n,
	input logic                     io_wait,
	input logic                     sys_reset,
	input logic                     mgmt_read,
	input logic                     mgmt_write,
	input logic                     mgmt_waitrequest,
	input emu_mgmt_pkg::mgmt_addr_t mgmt_addr,
	input emu_mgmt_pkg::mgmt_data_t mgmt_wdata
);

	// Number of assertion failures
	int fail_count = 0;

	// Command and payload frozen while the slave stalls unless aborted
	property cmd_held;
		@(posedge clk_sys) disable iff (!rst_n || sys_reset)
		(mgmt_read || mgmt_write) && mgmt_waitrequest |=>
			$stable(mgmt_read) && $stable(mgmt_write) &&
			$stable(mgmt_addr) && $stable(mgmt_wdata);
	endproperty

	assert property (cmd_held) else begin
		fail_count++;
		$error("Command or payload changed while waitrequest was high");
	end

	assert property (@(posedge clk_sys) disable iff (!rst_n) !(mgmt_read && mgmt_write)) else begin
		fail_count++;
		$error("mgmt_read and mgmt_write high together");
	end

	// A bus command only exists inside a host access
	assert property (@(posedge clk_sys) disable iff (!rst_n)
		(mgmt_read || mgmt_write) |-> io_wait) else begin
		fail_count++;
		$error("Bus command issued while io_wait is low");
	end

endmodule

bind mgmt_access_fsm emu_mgmt_assertions u_assert (
	.clk_sys          (clk_sys),
	.rst_n            (rst_n),
	.io_wait          (io_wait),
	.sys_reset        (sys_reset),
	.mgmt_read        (mgmt_read),
	.mgmt_write       (mgmt_write),
	.mgmt_waitrequest (mgmt_waitrequest),
	.mgmt_addr        (mgmt_addr),
	.mgmt_wdata       (mgmt_wdata)
);

// ==== sim/emu_mgmt_tb.sv ====
`timescale 1ns/1ps

`include "emu_mgmt_defines.svh"

module emu_mgmt_tb;
	import emu_mgmt_pkg::*;

	localparam int RST_CYCLES      = 16;
	localparam int NUM_OPS         = 200;
	localparam int DIRECTED_OPS    = 40;
	localparam int ACCESS_TIMEOUT  = 100;
	localparam int WATCHDOG_CYCLES = (NUM_OPS + DIRECTED_OPS) * 40 + RST_CYCLES;

	logic       clk_sys;
	logic       rst_n;
	logic       host_rd;
	logic       host_wr;
	mgmt_addr_t host_addr;
	mgmt_data_t host_wdata;
	logic       io_wait;
	mgmt_data_t host_rdata;
	logic       mgmt_waitrequest;
	logic       mgmt_rdatavalid;
	mgmt_data_t mgmt_rdata;
	logic       mgmt_read;
	logic       mgmt_write;
	mgmt_addr_t mgmt_addr;
	mgmt_data_t mgmt_wdata;
	logic       status_reset;
	logic       user_button;
	logic       kbd_reset_n;
	logic       sys_reset;
	logic       cpu_reset;
	logic       device;
	logic       led_hdd;
	logic       led_fdd;

	// Bus model state
	mgmt_data_t mem [16];
	mgmt_data_t ref_mem [16];
	int         wait_left;
	int         cmd_age;
	int         stall_cycles;
	logic       rd_pending;
	int         rd_delay;
	mgmt_data_t rd_word;
	mgmt_addr_t exp_addr;
	mgmt_data_t exp_wdata;

	integer     seed;
	int         errors;
	int         checks;

	emu_mgmt_top dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// Power-on contents distinct for every word
	function automatic mgmt_data_t fill_word(input int idx);
		return 32'h5a00_0000 ^ (idx * 32'h0101_0101);
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Fail %s: expected %h, got %h at %0t", name, exp, got, $time);
		end
	endtask

	task automatic expect_true(input bit cond, input string what);
		checks++;
		assert (cond) else begin
			errors++;
			$display("Error: %s at %0t", what, $time);
		end
	endtask

	// ======================================================================
	// Management bus slave model
	// ======================================================================

	// Random wait states plus an optional forced stall per command
	assign mgmt_waitrequest = (wait_left != 0) || (cmd_age < stall_cycles);

	always @(posedge clk_sys) begin
		mgmt_rdatavalid <= 1'b0;
		if (!rst_n) begin
			wait_left  <= 0;
			cmd_age    <= 0;
			rd_pending <= 1'b0;
		end else begin
			if ((mgmt_read || mgmt_write) && !mgmt_waitrequest) begin
				cmd_age   <= 0;
				wait_left <= {$random(seed)} % 4;
				if (mgmt_write) begin
					mem[mgmt_addr[3:0]] <= mgmt_wdata;
				end else begin
					rd_pending <= 1'b1;
					rd_delay   <= 1 + {$random(seed)} % 4;
					rd_word    <= mem[mgmt_addr[3:0]];
				end
			end else if (mgmt_read || mgmt_write) begin
				cmd_age <= cmd_age + 1;
				if (wait_left != 0) begin
					wait_left <= wait_left - 1;
				end
			end else begin
				cmd_age <= 0;
			end

			if (rd_pending) begin
				if (rd_delay == 1) begin
					mgmt_rdatavalid <= 1'b1;
					mgmt_rdata      <= rd_word;
					rd_pending      <= 1'b0;
				end else begin
					rd_delay <= rd_delay - 1;
				end
			end

			// Payload must match the captured host request on every command cycle
			if (mgmt_read || mgmt_write) begin
				compare_value("mgmt_addr", mgmt_addr, exp_addr);
			end
			if (mgmt_write) begin
				compare_value("mgmt_wdata", mgmt_wdata, exp_wdata);
			end
		end
	end

	// ======================================================================
	// Host side tasks
	// ======================================================================

	task automatic start_access(input logic is_wr, input mgmt_addr_t addr,
			input mgmt_data_t data, input logic dev);
		@(posedge clk_sys);
		host_rd    <= ~is_wr;
		host_wr    <= is_wr;
		host_addr  <= addr;
		host_wdata <= data;
		device     <= dev;
		exp_addr   <= addr;
		exp_wdata  <= data;
		@(posedge clk_sys);
		host_rd <= 1'b0;
		host_wr <= 1'b0;
		#1;
		compare_value("io_wait", io_wait, 1'b1);
	endtask

	// The falling edge of io_wait ends each access
	task automatic wait_done(output int cycles);
		cycles = 0;
		while (io_wait !== 1'b0 && cycles < ACCESS_TIMEOUT) begin
			@(posedge clk_sys);
			#1;
			cycles++;
		end
		expect_true(io_wait === 1'b0, "access did not finish, io_wait stayed high");
	endtask

	task automatic do_access(input logic is_wr, input mgmt_addr_t addr,
			input mgmt_data_t data, input logic dev);
		int cycles;
		start_access(is_wr, addr, data, dev);
		wait_done(cycles);
		if (is_wr) begin
			ref_mem[addr[3:0]] = data;
		end else begin
			compare_value("host_rdata", host_rdata, ref_mem[addr[3:0]]);
		end
	endtask

	// Stretch starts 3 cycles after the edge
	// LEDs stay dark throughout
	task automatic apply_status_reset(input bit first);
		bit exp_rst;
		@(posedge clk_sys);
		status_reset <= 1'b1;
		for (int k = 1; k <= `EMU_RST_STRETCH + 4; k++) begin
			@(posedge clk_sys);
			#1;
			exp_rst = (k >= 3 && k <= `EMU_RST_STRETCH + 2) || (first && k < 3);
			compare_value("sys_reset", sys_reset, exp_rst);
			if (sys_reset === 1'b1) begin
				expect_true(led_hdd === 1'b0 && led_fdd === 1'b0,
					"disk LED lit while sys_reset is high");
			end
		end
		@(posedge clk_sys);
		status_reset <= 1'b0;
	endtask

	task automatic check_cpu_reset_source(input bit use_kbd);
		repeat (2) @(posedge clk_sys);
		#1;
		compare_value("cpu_reset", cpu_reset, 1'b0);
		@(posedge clk_sys);
		user_button <= ~use_kbd;
		kbd_reset_n <= ~use_kbd;
		#1;
		compare_value("cpu_reset", cpu_reset, 1'b0);
		@(posedge clk_sys);
		user_button <= 1'b0;
		kbd_reset_n <= 1'b1;
		#1;
		compare_value("cpu_reset", cpu_reset, 1'b1);
		@(posedge clk_sys);
		#1;
		compare_value("cpu_reset", cpu_reset, 1'b0);
	endtask

	task automatic check_led_hold(input logic dev);
		int         n;
		mgmt_data_t data;
		data = $random(seed);
		start_access(1'b1, 32'h0000_0040 | dev, data, dev);
		@(posedge clk_sys);
		#1;
		compare_value(dev ? "led_hdd" : "led_fdd", dev ? led_hdd : led_fdd, 1'b1);
		wait_done(n);
		ref_mem[dev] = data;
		n = 0;
		while ((dev ? led_hdd : led_fdd) === 1'b1 && n < 2 * `EMU_LED_HOLD) begin
			expect_true((dev ? led_fdd : led_hdd) === 1'b0, "LED of the other device lit");
			@(posedge clk_sys);
			#1;
			n++;
		end
		compare_value("LED hold cycles", n, `EMU_LED_HOLD);
	endtask

	// ======================================================================
	// Test sequence
	// ======================================================================

	initial begin
		mgmt_addr_t  addr;
		mgmt_data_t  data;
		logic [31:0] rnd;
		int          n;

		seed = 32'h1cb;
		errors = 0;
		checks = 0;
		rst_n = 1'b0;
		host_rd = 1'b0;
		host_wr = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		status_reset = 1'b0;
		user_button = 1'b0;
		kbd_reset_n = 1'b1;
		device = 1'b0;
		mgmt_rdatavalid = 1'b0;
		mgmt_rdata = '0;
		wait_left = 0;
		cmd_age = 0;
		stall_cycles = 0;
		rd_pending = 1'b0;
		rd_delay = 0;
		exp_addr = '0;
		exp_wdata = '0;
		for (int i = 0; i < 16; i++) begin
			mem[i] = fill_word(i);
			ref_mem[i] = fill_word(i);
		end

		repeat (RST_CYCLES) @(posedge clk_sys);
		rst_n <= 1'b1;
		#1;
		compare_value("io_wait", io_wait, 1'b0);
		compare_value("mgmt_read", mgmt_read, 1'b0);
		compare_value("mgmt_write", mgmt_write, 1'b0);
		compare_value("led_hdd", led_hdd, 1'b0);
		compare_value("led_fdd", led_fdd, 1'b0);
		compare_value("cpu_reset", cpu_reset, 1'b1);
		repeat (4) @(posedge clk_sys);
		#1;
		compare_value("sys_reset", sys_reset, 1'b1);

		apply_status_reset(1'b1);
		check_cpu_reset_source(1'b0);
		check_cpu_reset_source(1'b1);

		// Random host traffic
		for (int i = 0; i < NUM_OPS; i++) begin
			rnd = $random(seed);
			addr = $random(seed);
			data = $random(seed);
			do_access(rnd[0], addr, data, rnd[1]);
			repeat (rnd[3:2]) @(posedge clk_sys);
		end

		// Long waitrequest on a write and then on a read of the same word
		@(posedge clk_sys);
		stall_cycles <= 12;
		addr = 32'h0000_0105;
		data = $random(seed);
		start_access(1'b1, addr, data, 1'b0);
		wait_done(n);
		expect_true(n > 12, "write finished while waitrequest was forced high");
		ref_mem[addr[3:0]] = data;
		start_access(1'b0, addr, '0, 1'b0);
		wait_done(n);
		expect_true(n > 12, "read finished while waitrequest was forced high");
		compare_value("host_rdata", host_rdata, ref_mem[addr[3:0]]);
		@(posedge clk_sys);
		stall_cycles <= 0;

		// LEDs start dark and light one device at a time
		repeat (`EMU_LED_HOLD + 8) @(posedge clk_sys);
		#1;
		compare_value("led_hdd", led_hdd, 1'b0);
		compare_value("led_fdd", led_fdd, 1'b0);
		check_led_hold(1'b1);
		check_led_hold(1'b0);

		// Write stalled for good and killed by a reset-apply edge
		addr = 32'h0000_0009;
		data = $random(seed);
		@(posedge clk_sys);
		stall_cycles <= 1000;
		start_access(1'b1, addr, data, 1'b1);
		repeat (6) @(posedge clk_sys);
		#1;
		compare_value("mgmt_write", mgmt_write, 1'b1);
		apply_status_reset(1'b0);
		#1;
		compare_value("io_wait", io_wait, 1'b0);
		compare_value("mgmt_write", mgmt_write, 1'b0);
		@(posedge clk_sys);
		stall_cycles <= 0;
		do_access(1'b0, addr, '0, 1'b1);
		do_access(1'b1, addr, data, 1'b1);
		do_access(1'b0, addr, '0, 1'b1);

		repeat (4) @(posedge clk_sys);
		$display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
			dut.u_access.u_assert.fail_count);
		if (errors == 0 && dut.u_access.u_assert.fail_count == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
		$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== emu_mgmt_top.f ====
+incdir+logic
logic/emu_mgmt_pkg.sv
logic/mgmt_access_fsm.sv
logic/reset_sequencer.sv
logic/activity_indicator.sv
logic/emu_mgmt_top.sv
sim/emu_mgmt_assertions.sv
sim/emu_mgmt_tb.sv

// ==== Bender.yml ====
package:
  name: emu_mgmt

sources:
  - include_dirs:
      - logic
    files:
      - logic/emu_mgmt_pkg.sv
      - logic/mgmt_access_fsm.sv
      - logic/reset_sequencer.sv
      - logic/activity_indicator.sv
      - logic/emu_mgmt_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - sim/emu_mgmt_assertions.sv
      - sim/emu_mgmt_tb.sv
